// File: sim.f
+incdir+verilog
verilog/ads_cmd_pkg.sv
verilog/ads_bus_pkg.sv
verilog/spi_byte_engine.sv
verilog/ecg_frame_assembler.sv
verilog/ads_sequencer.sv
verilog/ads1292_ctrl_top.sv
tb/ads1292_model.sv
tb/tb_ads1292.sv

// File: tb/tb_ads1292.sv
`include "ads_defs.svh"

module tb_ads1292;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 12;
	localparam int FRAMES    = 3;   // Frames checked in continuous mode
	localparam int LIMIT     = NUM_TESTS * 2000 + 3 * 400 * FRAMES;

	typedef enum {K_PIN, K_SPI, K_WREG, K_RREG, K_RDATAC, K_SDATAC} kind_e;

	logic                       clk;
	logic                       rstn;
	ads_bus_pkg::ads_host_req_t host;
	ads_bus_pkg::ads_frame_t    frame;
	logic                       frame_valid;
	logic                       busy;
	logic                       sclk;
	logic                       mosi;
	logic                       csn;
	logic                       start;
	logic                       pwdn_n;
	logic                       miso;
	logic                       drdy_n;

	// Test table
	string                  t_name [NUM_TESTS];
	ads_cmd_pkg::ads_ctrl_e t_ctrl [NUM_TESTS];
	logic [7:0]             t_cmd [NUM_TESTS];
	logic [7:0]             t_addr [NUM_TESTS];
	logic [7:0]             t_wdata [NUM_TESTS];
	kind_e                  t_kind [NUM_TESTS];
	logic                   t_start [NUM_TESTS]; // START level after a pin command
	logic                   t_pwdn [NUM_TESTS];  // PWDN level while busy
	logic [7:0]             t_byte [NUM_TESTS];  // Logged opcode or read data
	bit                     t_seed [NUM_TESTS];  // Read data comes from power-on value
	int                     n_tests = 0;

	int    mismatch_cnt = 0;
	int    other_cnt = 0;
	string cur_name = "reset";

	ads1292_ctrl_top dut0 (
		.clk(clk), .rstn(rstn), .i_host(host),
		.o_frame(frame), .o_frame_valid(frame_valid), .o_busy(busy),
		.o_spi_sclk(sclk), .o_spi_mosi(mosi), .o_spi_csn(csn),
		.o_start(start), .o_pwdn_n(pwdn_n),
		.i_spi_miso(miso), .i_drdy_n(drdy_n)
	);

	ads1292_model adc0 (
		.clk(clk), .rstn(rstn), .i_sclk(sclk), .i_mosi(mosi), .i_csn(csn),
		.i_start(start), .i_pwdn_n(pwdn_n), .o_miso(miso), .o_drdy_n(drdy_n)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	task automatic add_test(input string name, input ads_cmd_pkg::ads_ctrl_e ctrl,
		input logic [7:0] cmd, input logic [7:0] addr, input logic [7:0] wdata,
		input kind_e kind, input logic st, input logic pd, input logic [7:0] b,
		input bit sd);
		t_name[n_tests]  = name;
		t_ctrl[n_tests]  = ctrl;
		t_cmd[n_tests]   = cmd;
		t_addr[n_tests]  = addr;
		t_wdata[n_tests] = wdata;
		t_kind[n_tests]  = kind;
		t_start[n_tests] = st;
		t_pwdn[n_tests]  = pd;
		t_byte[n_tests]  = b;
		t_seed[n_tests]  = sd;
		n_tests++;
	endtask

	// Outputs settled, inputs may change
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_frame(input string name, input ads_bus_pkg::ads_frame_t exp,
		input ads_bus_pkg::ads_frame_t act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_pin(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	function automatic ads_bus_pkg::ads_frame_t expected_frame(input int k);
		ads_bus_pkg::ads_frame_t f;
		f.status = {16'hC000, k[7:0]};
		f.ch1    = 24'(k * 3);
		f.ch2    = 24'(k * 5 + 1);
		return f;
	endfunction

	task automatic wait_idle();
		while (busy)
			next_cycle();
		host.ctrl = ads_cmd_pkg::CTRL_IDLE;
	endtask

	task automatic run_test(input int i);
		int                      n;
		int                      log0;
		int                      fv_seen;
		logic                    pwdn_busy;
		logic                    csn_dropped;
		logic [7:0]              exp_b;
		ads_bus_pkg::ads_frame_t exp_f;
		cur_name = t_name[i];
		log0     = adc0.log_cnt;
		host     = '{t_ctrl[i], t_cmd[i], t_addr[i], t_wdata[i]};
		if (t_kind[i] != K_SDATAC) begin
			while (!busy)
				next_cycle();
			pwdn_busy   = pwdn_n;
			csn_dropped = !csn;
			host.ctrl   = ads_cmd_pkg::CTRL_IDLE; // Busy seen, drop request
		end
		case (t_kind[i])
			K_PIN: begin
				n = 0;
				while (busy) begin
					next_cycle();
					n++;
					if (!csn)
						csn_dropped = 1'b1;
				end
				if (n > 2) begin
					$display("%s: pin command stayed busy for %0d cycles", cur_name, n);
					other_cnt++;
				end
				check_pin({cur_name, "_pwdn_busy"}, t_pwdn[i], pwdn_busy);
				check_pin({cur_name, "_pwdn_after"}, 1'b1, pwdn_n);
				check_pin({cur_name, "_start"}, t_start[i], start);
				check_pin({cur_name, "_csn_low"}, 1'b0, csn_dropped);
				check_byte({cur_name, "_log_count"}, 8'(log0), 8'(adc0.log_cnt));
			end
			K_SPI, K_WREG, K_RREG: begin
				wait_idle();
				check_pin({cur_name, "_csn"}, 1'b1, csn);
				check_byte({cur_name, "_log_count"}, 8'(log0 + 1), 8'(adc0.log_cnt));
				if (t_kind[i] == K_RREG) begin
					exp_b = t_seed[i] ? adc0.regs[t_addr[i][4:0]] : t_byte[i];
					exp_f = '0;
					exp_f.ch2[7:0] = exp_b; // Zeros above the read byte
					check_byte({cur_name, "_data"}, exp_b, frame[7:0]);
					check_frame({cur_name, "_frame"}, exp_f, frame);
				end else begin
					check_byte({cur_name, "_log"}, t_byte[i], adc0.log_mem[log0]);
				end
			end
			K_RDATAC: begin
				for (int k = 0; k < FRAMES; k++) begin
					while (!frame_valid)
						next_cycle();
					check_frame($sformatf("%s_frame%0d", cur_name, k), expected_frame(k), frame);
					check_pin({cur_name, "_busy"}, 1'b1, busy);
					check_pin({cur_name, "_start"}, 1'b1, start);
					next_cycle(); // Past the strobe
				end
				check_byte({cur_name, "_log"}, t_byte[i], adc0.log_mem[log0]);
			end
			default: begin // Stop from between frames
				wait_idle();
				check_byte({cur_name, "_log"}, t_byte[i], adc0.log_mem[adc0.log_cnt - 1]);
				check_pin({cur_name, "_start"}, 1'b0, start);
				check_pin({cur_name, "_csn"}, 1'b1, csn);
				fv_seen = 0;
				repeat (1000) begin
					next_cycle();
					if (frame_valid)
						fv_seen++;
				end
				check_byte({cur_name, "_late_frames"}, 8'd0, 8'(fv_seen));
			end
		endcase
	endtask

	// Watchdog sized from the table and frame count
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Test %s hung with no response after %0d cycles", cur_name, LIMIT);
		other_cnt++;
		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		$display("Regression failed");
		$finish;
	end

	initial begin
		host = '0;
		rstn = 1'b0;
		add_test("cmd_start", ads_cmd_pkg::CTRL_SYSCMD, 8'h08, 0, 0, K_PIN, 1, 1, 0, 0);
		add_test("cmd_stop", ads_cmd_pkg::CTRL_SYSCMD, 8'h0A, 0, 0, K_PIN, 0, 1, 0, 0);
		add_test("cmd_reset", ads_cmd_pkg::CTRL_SYSCMD, 8'h06, 0, 0, K_PIN, 0, 0, 0, 0);
		add_test("cmd_wakeup", ads_cmd_pkg::CTRL_SYSCMD, 8'h02, 0, 0, K_SPI, 0, 1, 8'h02, 0);
		add_test("cmd_standby", ads_cmd_pkg::CTRL_SYSCMD, 8'h04, 0, 0, K_SPI, 0, 1, 8'h04, 0);
		add_test("wreg_a05", ads_cmd_pkg::CTRL_WREG, 0, 8'h05, 8'hA7, K_WREG, 0, 1, 8'h45, 0);
		add_test("rreg_a05", ads_cmd_pkg::CTRL_RREG, 0, 8'h05, 0, K_RREG, 0, 1, 8'hA7, 0);
		add_test("wreg_a1e", ads_cmd_pkg::CTRL_WREG, 0, 8'h1E, 8'h3C, K_WREG, 0, 1, 8'h5E, 0);
		add_test("rreg_a1e", ads_cmd_pkg::CTRL_RREG, 0, 8'h1E, 0, K_RREG, 0, 1, 8'h3C, 0);
		add_test("rreg_a0b", ads_cmd_pkg::CTRL_RREG, 0, 8'h0B, 0, K_RREG, 0, 1, 0, 1);
		add_test("rdatac", ads_cmd_pkg::CTRL_RDATAC, 0, 0, 0, K_RDATAC, 1, 1, 8'h10, 0);
		add_test("sdatac", ads_cmd_pkg::CTRL_SDATAC, 0, 0, 0, K_SDATAC, 0, 1, 8'h11, 0);
		repeat (8) @(posedge clk);
		#2;
		rstn = 1'b1;
		next_cycle();
		check_pin("reset_csn", 1'b1, csn);
		check_pin("reset_start", 1'b0, start);
		check_pin("reset_pwdn", 1'b1, pwdn_n);
		check_pin("reset_busy", 1'b0, busy);
		check_pin("reset_frame_valid", 1'b0, frame_valid);
		check_pin("reset_sclk", 1'b0, sclk);
		check_frame("reset_frame", '0, frame);
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
			repeat (4) next_cycle();
		end
		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt + other_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: tb/ads1292_model.sv
`include "ads_defs.svh"

// Behavioural mode 0 ADC slave shifting MSB first
module ads1292_model (
	input  logic clk,
	input  logic rstn,
	input  logic i_sclk,
	input  logic i_mosi,
	input  logic i_csn,
	input  logic i_start,
	input  logic i_pwdn_n,
	output logic o_miso,
	output logic o_drdy_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRDY_PERIOD = 400; // Clocks between conversions
	localparam int DRDY_LOW    = 4;
	localparam int DEC_CMD     = 0;
	localparam int DEC_WR_NUM  = 1;
	localparam int DEC_WR_DATA = 2;
	localparam int DEC_RD_NUM  = 3;
	localparam int DEC_RD_DATA = 4;

	logic [`ADS_BYTE_W-1:0] regs [0:31];    // Device register file
	logic [`ADS_BYTE_W-1:0] log_mem [0:63]; // Opcode bytes seen on MOSI
	int                     log_cnt = 0;
	integer                 seed;
	int                     bit_cnt = 0;    // Rising edges in current byte
	int                     dec = DEC_CMD;  // Byte decoder state
	int                     bytes_read = 0; // Frame bytes since RDATAC
	int                     drdy_cnt;
	bit                     rdatac = 0;
	logic [4:0]             addr;
	logic [`ADS_BYTE_W-1:0] rx_sh;
	logic [`ADS_BYTE_W-1:0] cur_byte;       // Byte going out on MISO
	logic [71:0]            frame_word;

	initial begin
		seed = 32'h3d75_62e0;
		for (int i = 0; i < 32; i++)
			regs[i] = 8'($random(seed)); // Power-on contents
	end

	// Frame k has status C000kk with ch1 = 3k and ch2 = 5k + 1
	function automatic logic [71:0] frame_pattern(input int k);
		logic [23:0] st;
		st = {16'hC000, k[7:0]};
		return {st, 24'(k * 3), 24'(k * 5 + 1)};
	endfunction

	always_comb begin
		frame_word = frame_pattern(bytes_read / `ADS_FRAME_BYTES);
		if (rdatac)
			cur_byte = frame_word[71 - 8 * (bytes_read % `ADS_FRAME_BYTES) -: 8];
		else if (dec == DEC_RD_DATA)
			cur_byte = regs[addr]; // RREG reply
		else
			cur_byte = '0;
	end

	assign o_miso = cur_byte[7 - bit_cnt]; // Moves right after each rise

	task automatic take_byte(input logic [7:0] b);
		case (dec)
			DEC_CMD: begin
				if (rdatac && b != ads_cmd_pkg::CMD_SDATAC) begin
					bytes_read++; // Dummy byte of a frame
				end else begin
					log_mem[log_cnt] = b;
					log_cnt++;
					if (b == ads_cmd_pkg::CMD_SDATAC) begin
						rdatac = 0;
					end else if (b == ads_cmd_pkg::CMD_RDATAC) begin
						rdatac     = 1;
						bytes_read = 0;
					end else if (b[7:5] == ads_cmd_pkg::OP_WREG) begin
						addr = b[4:0];
						dec  = DEC_WR_NUM;
					end else if (b[7:5] == ads_cmd_pkg::OP_RREG) begin
						addr = b[4:0];
						dec  = DEC_RD_NUM;
					end
				end
			end
			DEC_WR_NUM:  dec = DEC_WR_DATA; // Count byte is always one here
			DEC_WR_DATA: begin
				regs[addr] = b;
				dec        = DEC_CMD;
			end
			DEC_RD_NUM:  dec = DEC_RD_DATA;
			default:     dec = DEC_CMD;
		endcase
	endtask

	// MOSI taken on rising SCLK and CSN high resets the decoder
	always @(posedge i_sclk or posedge i_csn) begin
		if (i_csn) begin
			bit_cnt = 0;
			dec     = DEC_CMD;
		end else begin
			rx_sh = {rx_sh[6:0], i_mosi};
			if (bit_cnt == 7) begin
				bit_cnt = 0;
				take_byte(rx_sh);
			end else begin
				bit_cnt++;
			end
		end
	end

	// DRDY low for the last few clocks of every period
	always @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_drdy_n <= 1'b1;
			drdy_cnt <= 0;
		end else if (rdatac && i_start && i_pwdn_n) begin
			drdy_cnt <= (drdy_cnt == DRDY_PERIOD - 1) ? 0 : drdy_cnt + 1;
			o_drdy_n <= (drdy_cnt < DRDY_PERIOD - DRDY_LOW - 1);
		end else begin
			drdy_cnt <= 0;
			o_drdy_n <= 1'b1; // Conversions stopped
		end
	end

endmodule

// File: verilog/ads1292_ctrl_top.sv
`include "ads_defs.svh"

// Host controller for the two channel ECG ADC
module ads1292_ctrl_top (
	input  logic                       clk,
	input  logic                       rstn,
	input  ads_bus_pkg::ads_host_req_t i_host,
	output ads_bus_pkg::ads_frame_t    o_frame,
	output logic                       o_frame_valid,
	output logic                       o_busy,
	output logic                       o_spi_sclk,
	output logic                       o_spi_mosi,
	output logic                       o_spi_csn,
	output logic                       o_start,
	output logic                       o_pwdn_n, // Active low power down / reset
	input  logic                       i_spi_miso,
	input  logic                       i_drdy_n
);

	ads_bus_pkg::spi_xfer_t xfer; // Sequencer to engine
	logic                   tx_ready;
	logic                   rx_valid;
	logic [`ADS_BYTE_W-1:0] rx_byte;
	logic                   clear;
	logic                   capture;
	logic                   frame_done;

	ads_sequencer u_seq (
		.clk(clk),
		.rstn(rstn),
		.i_host(i_host),
		.i_drdy_n(i_drdy_n),
		.i_tx_ready(tx_ready),
		.i_rx_valid(rx_valid),
		.i_frame_done(frame_done),
		.o_xfer(xfer),
		.o_clear(clear),
		.o_capture(capture),
		.o_frame_valid(o_frame_valid),
		.o_busy(o_busy),
		.o_spi_csn(o_spi_csn),
		.o_start(o_start),
		.o_pwdn_n(o_pwdn_n)
	);

	spi_byte_engine u_spi (
		.clk(clk),
		.rstn(rstn),
		.i_xfer(xfer),
		.i_spi_miso(i_spi_miso),
		.o_tx_ready(tx_ready),
		.o_rx_valid(rx_valid),
		.o_rx_byte(rx_byte),
		.o_spi_sclk(o_spi_sclk),
		.o_spi_mosi(o_spi_mosi)
	);

	// Bytes land here only while capture is up
	ecg_frame_assembler u_asm (
		.clk(clk),
		.rstn(rstn),
		.i_clear(clear),
		.i_capture(capture),
		.i_rx_valid(rx_valid),
		.i_rx_byte(rx_byte),
		.o_frame(o_frame),
		.o_frame_done(frame_done)
	);

endmodule

// File: verilog/ads_sequencer.sv
`include "ads_defs.svh"

// Command, register and continuous read FSM
module ads_sequencer (
	input  logic                       clk,
	input  logic                       rstn,
	input  ads_bus_pkg::ads_host_req_t i_host,
	input  logic                       i_drdy_n,
	input  logic                       i_tx_ready,
	input  logic                       i_rx_valid,
	input  logic                       i_frame_done,
	output ads_bus_pkg::spi_xfer_t     o_xfer,
	output logic                       o_clear,
	output logic                       o_capture,
	output logic                       o_frame_valid,
	output logic                       o_busy,
	output logic                       o_spi_csn,
	output logic                       o_start,
	output logic                       o_pwdn_n
);

	localparam int CNT_MAX = (`ADS_CSN_HOLD > `ADS_SDATAC_GUARD) ?
		`ADS_CSN_HOLD : `ADS_SDATAC_GUARD;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_PIN,       // Pin command, release reset and finish
		S_CMD,       // Other system command byte
		S_WR_OP,
		S_WR_NUM,
		S_WR_DATA,
		S_RD_OP,
		S_RD_NUM,
		S_RD_DATA,   // Dummy byte, reply captured
		S_RDC_OP,    // RDATAC opcode
		S_RDC_WAIT,  // Between frames, SDATAC accepted here
		S_RDC_BYTE,  // Dummy byte of a frame
		S_RDC_CHK,   // Frame complete or next byte
		S_SDC_GUARD, // Keep-out after DRDY
		S_SDC_OP,    // SDATAC opcode
		S_HOLD       // CSN low tail
	} state_e;

	state_e                 state;
	logic                   sent;      // Byte of this state is in flight
	logic                   byte_done; // In-flight byte finished
	logic                   is_byte;   // State shifts a byte
	logic [`ADS_BYTE_W-1:0] tx_data;
	logic [CNT_W-1:0]       cnt;       // CSN hold and SDATAC guard
	logic                   drdy_q;
	logic                   drdy_fall;
	logic [`ADS_BYTE_W-1:0] cmd_q;
	logic [`ADS_BYTE_W-1:0] addr_q;
	logic [`ADS_BYTE_W-1:0] wdata_q;

	assign drdy_fall = drdy_q && !i_drdy_n;
	assign byte_done = sent && i_rx_valid;

	// Byte to shift for each byte state
	always_comb begin
		is_byte = 1'b1;
		tx_data = '0; // Dummy for reads
		case (state)
			S_CMD:     tx_data = cmd_q;
			S_WR_OP:   tx_data = {ads_cmd_pkg::OP_WREG, addr_q[4:0]};
			S_WR_NUM:  tx_data = ads_cmd_pkg::OP_NUM_ONE;
			S_WR_DATA: tx_data = wdata_q;
			S_RD_OP:   tx_data = {ads_cmd_pkg::OP_RREG, addr_q[4:0]};
			S_RD_NUM:  tx_data = ads_cmd_pkg::OP_NUM_ONE;
			S_RD_DATA,
			S_RDC_BYTE: tx_data = '0;
			S_RDC_OP:  tx_data = ads_cmd_pkg::CMD_RDATAC;
			S_SDC_OP:  tx_data = ads_cmd_pkg::CMD_SDATAC;
			default:   is_byte = 1'b0;
		endcase
	end

	assign o_xfer.valid = is_byte && !sent && i_tx_ready; // One strobe per state
	assign o_xfer.data  = tx_data;
	assign o_capture    = (state == S_RD_DATA) || (state == S_RDC_BYTE) ||
		(state == S_RDC_CHK); // Held across a whole frame

	// Request fields, only taken at idle
	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			cmd_q   <= i_host.cmd;
			addr_q  <= i_host.addr;
			wdata_q <= i_host.wdata;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= S_IDLE;
			sent          <= 1'b0;
			cnt           <= '0;
			drdy_q        <= 1'b1;
			o_clear       <= 1'b0;
			o_frame_valid <= 1'b0;
			o_busy        <= 1'b0;
			o_spi_csn     <= 1'b1;
			o_start       <= 1'b0;
			o_pwdn_n      <= 1'b1;
		end else begin
			drdy_q        <= i_drdy_n;
			o_clear       <= 1'b0;
			o_frame_valid <= 1'b0;
			cnt           <= '0; // Counting states override
			if (o_xfer.valid)
				sent <= 1'b1;
			else if (i_rx_valid)
				sent <= 1'b0;

			case (state)
				S_IDLE: begin
					case (i_host.ctrl)
						ads_cmd_pkg::CTRL_SYSCMD: begin
							o_busy <= 1'b1;
							state  <= S_PIN;
							if (i_host.cmd == ads_cmd_pkg::CMD_START)
								o_start <= 1'b1;
							else if (i_host.cmd == ads_cmd_pkg::CMD_STOP)
								o_start <= 1'b0;
							else if (i_host.cmd == ads_cmd_pkg::CMD_RESET)
								o_pwdn_n <= 1'b0; // One clock reset pulse
							else begin
								o_spi_csn <= 1'b0; // Goes out over SPI
								state     <= S_CMD;
							end
						end
						ads_cmd_pkg::CTRL_WREG: begin
							o_busy    <= 1'b1;
							o_spi_csn <= 1'b0;
							state     <= S_WR_OP;
						end
						ads_cmd_pkg::CTRL_RREG: begin
							o_busy    <= 1'b1;
							o_spi_csn <= 1'b0;
							o_clear   <= 1'b1; // Result is the read byte only
							state     <= S_RD_OP;
						end
						ads_cmd_pkg::CTRL_RDATAC: begin
							o_busy    <= 1'b1;
							o_spi_csn <= 1'b0; // Low for the whole mode
							state     <= S_RDC_OP;
						end
						default: ; // SDATAC means nothing outside continuous mode
					endcase
				end
				S_PIN: begin
					o_pwdn_n <= 1'b1;
					o_busy   <= 1'b0;
					state    <= S_IDLE;
				end
				S_CMD:     if (byte_done) state <= S_HOLD;
				S_WR_OP:   if (byte_done) state <= S_WR_NUM;
				S_WR_NUM:  if (byte_done) state <= S_WR_DATA;
				S_WR_DATA: if (byte_done) state <= S_HOLD;
				S_RD_OP:   if (byte_done) state <= S_RD_NUM;
				S_RD_NUM:  if (byte_done) state <= S_RD_DATA;
				S_RD_DATA: if (byte_done) state <= S_HOLD;
				S_RDC_OP: begin
					if (byte_done) begin
						o_start <= 1'b1; // Conversions run from here on
						state   <= S_RDC_WAIT;
					end
				end
				S_RDC_WAIT: begin
					if (drdy_fall) begin
						o_clear <= 1'b1;
						state   <= S_RDC_BYTE;
					end else if (i_host.ctrl == ads_cmd_pkg::CTRL_SDATAC) begin
						state <= S_SDC_GUARD;
					end
				end
				S_RDC_BYTE: if (byte_done) state <= S_RDC_CHK;
				S_RDC_CHK: begin
					if (i_frame_done) begin
						o_frame_valid <= 1'b1; // Frame already on o_frame
						state         <= S_RDC_WAIT;
					end else begin
						state <= S_RDC_BYTE;
					end
				end
				S_SDC_GUARD: begin
					// Restart count while DRDY is low
					if (i_drdy_n) begin
						cnt <= cnt + 1'b1;
						if (cnt == CNT_W'(`ADS_SDATAC_GUARD - 1))
							state <= S_SDC_OP;
					end
				end
				S_SDC_OP: begin
					if (byte_done) begin
						o_start <= 1'b0;
						state   <= S_HOLD;
					end
				end
				S_HOLD: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`ADS_CSN_HOLD - 1)) begin
						o_spi_csn <= 1'b1;
						o_busy    <= 1'b0; // Falling busy ends the request
						state     <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/ecg_frame_assembler.sv
`include "ads_defs.svh"

// Collects received bytes into the 72 bit result
module ecg_frame_assembler (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    i_clear,   // Zero shift register and count
	input  logic                    i_capture, // Received bytes belong to the result
	input  logic                    i_rx_valid,
	input  logic [`ADS_BYTE_W-1:0]  i_rx_byte,
	output ads_bus_pkg::ads_frame_t o_frame,
	output logic                    o_frame_done
);

	localparam int FRAME_W = $bits(ads_bus_pkg::ads_frame_t);
	localparam int CNT_W   = $clog2(`ADS_FRAME_BYTES);

	logic [FRAME_W-1:0] shift_q;
	logic [FRAME_W-1:0] shift_next;
	logic [CNT_W-1:0]   byte_cnt;
	logic               take;
	logic               capture_q;

	assign take       = i_capture && i_rx_valid;
	assign shift_next = {shift_q[FRAME_W-`ADS_BYTE_W-1:0], i_rx_byte}; // In from low end

	always_ff @(posedge clk) begin
		if (i_clear)
			shift_q <= '0;
		else if (take)
			shift_q <= shift_next;
	end

	// Output only moves when a frame completes or capture ends (RREG)
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt     <= '0;
			capture_q    <= 1'b0;
			o_frame_done <= 1'b0;
			o_frame      <= '0;
		end else begin
			capture_q    <= i_capture;
			o_frame_done <= 1'b0;
			if (i_clear) begin
				byte_cnt <= '0;
			end else if (take) begin
				if (byte_cnt == CNT_W'(`ADS_FRAME_BYTES - 1)) begin
					byte_cnt     <= '0;
					o_frame      <= shift_next; // Ninth byte, whole frame
					o_frame_done <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end else if (capture_q && !i_capture) begin
				o_frame <= shift_q; // Short capture, zeros above
			end
		end
	end

endmodule

// File: verilog/spi_byte_engine.sv
`include "ads_defs.svh"

// Mode 0 SPI master, one byte per request
module spi_byte_engine (
	input  logic                   clk,
	input  logic                   rstn,
	input  ads_bus_pkg::spi_xfer_t i_xfer,
	input  logic                   i_spi_miso,
	output logic                   o_tx_ready,
	output logic                   o_rx_valid,
	output logic [`ADS_BYTE_W-1:0] o_rx_byte,
	output logic                   o_spi_sclk,
	output logic                   o_spi_mosi
);

	localparam int DIV_W  = $clog2(`ADS_CLKS_PER_HALF_BIT);
	localparam int EDGES  = 2 * `ADS_BYTE_W; // Rise and fall per bit
	localparam int EDGE_W = $clog2(EDGES + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ADS_CLKS_PER_HALF_BIT - 1);

	logic [DIV_W-1:0]       div_cnt;  // Clocks inside current half bit
	logic [EDGE_W-1:0]      edge_cnt; // SCLK edges still to make, 0 when idle
	logic [`ADS_BYTE_W-1:0] tx_shift; // MSB drives MOSI
	logic [`ADS_BYTE_W-1:0] rx_shift;
	logic                   start;
	logic                   half_tick; // SCLK toggles this cycle

	assign start     = i_xfer.valid && o_tx_ready;
	assign half_tick = (edge_cnt != '0) && (div_cnt == DIV_LAST);

	// Divider, edge count and handshake
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tx_ready <= 1'b1;
			o_rx_valid <= 1'b0;
			o_spi_sclk <= 1'b0; // CPOL 0
			div_cnt    <= '0;
			edge_cnt   <= '0;
		end else begin
			o_rx_valid <= 1'b0;
			if (start) begin
				o_tx_ready <= 1'b0;
				div_cnt    <= '0;
				edge_cnt   <= EDGE_W'(EDGES);
			end else if (half_tick) begin
				div_cnt    <= '0;
				o_spi_sclk <= ~o_spi_sclk;
				edge_cnt   <= edge_cnt - 1'b1;
				if (edge_cnt == EDGE_W'(1)) begin // Last falling edge
					o_rx_valid <= 1'b1;
					o_tx_ready <= 1'b1; // Next byte may follow at once
				end
			end else if (edge_cnt != '0) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Shift registers
	// MOSI changes on falling SCLK, MISO taken on rising SCLK
	always_ff @(posedge clk) begin
		if (start)
			tx_shift <= i_xfer.data; // Bit 7 set up a half bit before first rise
		else if (half_tick && o_spi_sclk)
			tx_shift <= {tx_shift[`ADS_BYTE_W-2:0], 1'b0};
		if (half_tick && !o_spi_sclk)
			rx_shift <= {rx_shift[`ADS_BYTE_W-2:0], i_spi_miso};
	end

	assign o_spi_mosi = tx_shift[`ADS_BYTE_W-1];
	assign o_rx_byte  = rx_shift; // Stable while rx_valid is high

endmodule

// File: verilog/ads_bus_pkg.sv
`include "ads_defs.svh"

package ads_bus_pkg;

	// Host request, sampled only while the sequencer is idle
	typedef struct packed {
		ads_cmd_pkg::ads_ctrl_e   ctrl;  // What to do
		logic [`ADS_BYTE_W-1:0]   cmd;   // SYSCMD opcode
		logic [`ADS_BYTE_W-1:0]   addr;  // Register address, low 5 bits used
		logic [`ADS_BYTE_W-1:0]   wdata; // WREG payload
	} ads_host_req_t;

	// Result word
	// MSB byte first off the wire lands in status[23:16]
	// RREG byte sits in ch2[7:0], rest zero
	typedef struct packed {
		logic [`ADS_SAMPLE_W-1:0] status;
		logic [`ADS_SAMPLE_W-1:0] ch1;
		logic [`ADS_SAMPLE_W-1:0] ch2;
	} ads_frame_t;

	// One byte handed to the SPI engine
	typedef struct packed {
		logic                   valid; // Single cycle strobe, only while engine ready
		logic [`ADS_BYTE_W-1:0] data;  // Byte for MOSI, MSB first
	} spi_xfer_t;

endpackage

// File: verilog/ads_cmd_pkg.sv
`include "ads_defs.svh"

package ads_cmd_pkg;

	// Host control code, held as a level by the host
	typedef enum logic [2:0] {
		CTRL_IDLE   = 3'd0, // Nothing to do
		CTRL_SYSCMD = 3'd1, // System command byte or pin action
		CTRL_WREG   = 3'd2, // Single register write
		CTRL_RREG   = 3'd3, // Single register read
		CTRL_RDATAC = 3'd4, // Enter read data continuous
		CTRL_SDATAC = 3'd5  // Leave continuous mode, only between frames
	} ads_ctrl_e;

	// System command opcodes
	localparam logic [`ADS_BYTE_W-1:0] CMD_RESET  = 8'h06; // Done on PWDN/RESET pin
	localparam logic [`ADS_BYTE_W-1:0] CMD_START  = 8'h08; // Done on START pin
	localparam logic [`ADS_BYTE_W-1:0] CMD_STOP   = 8'h0A; // Done on START pin
	localparam logic [`ADS_BYTE_W-1:0] CMD_RDATAC = 8'h10;
	localparam logic [`ADS_BYTE_W-1:0] CMD_SDATAC = 8'h11;

	// Register access, first byte is {op, addr[4:0]}
	localparam logic [2:0] OP_RREG = 3'b001;
	localparam logic [2:0] OP_WREG = 3'b010;

	// Second byte holds register count minus one
	localparam logic [`ADS_BYTE_W-1:0] OP_NUM_ONE = 8'h00;

endpackage

// File: verilog/ads_defs.svh
`ifndef ADS_DEFS_SVH
`define ADS_DEFS_SVH

// SPI clock divider
// System clocks per SCLK half period, 2 or more
`define ADS_CLKS_PER_HALF_BIT 2

// Data widths
`define ADS_BYTE_W 8 // One SPI byte
`define ADS_SAMPLE_W 24 // Status word or one channel sample

// RDATAC frame: status + ch1 + ch2, 3 bytes each
`define ADS_FRAME_BYTES 9

// CSN stays low this many clocks after the last byte (device wants >= 4 tCLK)
`define ADS_CSN_HOLD 8

// Keep-out after DRDY before SDATAC may go out
`define ADS_SDATAC_GUARD 4

`endif
